//--- build.f
+incdir+source
source/gpio_pkg.sv
source/gpio_apb_slave.sv
source/gpio_pin_sync.sv
source/gpio_lite_subunit.sv
source/gpio_top.sv
dv/gpio_props.sv
dv/gpio_tb.sv

//--- dv/gpio_props.sv
// gpio bus and pad assertions
`timescale 1ns/1ns

module gpio_props
  import gpio_pkg::*;
(
  input logic       pclk6,
  input logic       n_reset6,
  input logic       pready,
  input gpio_word_t prdata,
  input gpio_word_t test_tristate,
  input gpio_word_t pin_oe_n
);

  //------------------------------------------------------------
  // apb
  //------------------------------------------------------------
  // ready lasts one cycle, the next transfer needs a new setup
  a_ready_single: assert property (@(posedge pclk6) disable iff (!n_reset6)
    pready |=> !pready)
    else $error("pready high in two consecutive cycles");

  a_rdata_idle: assert property (@(posedge pclk6) disable iff (!n_reset6)
    !pready |-> (prdata == '0))   // bus reads zero outside ready
    else $error("prdata nonzero while pready is low");

  //------------------------------------------------------------
  // pads
  //------------------------------------------------------------
  // dft force wins over any register setting
  a_tristate: assert property (@(posedge pclk6) disable iff (!n_reset6)
    &(pin_oe_n | ~test_tristate))
    else $error("pad driven while test_tristate is set");

endmodule

bind gpio_top gpio_props i_props (
  .pclk6         (pclk6),
  .n_reset6      (n_reset6),
  .pready        (pready),
  .prdata        (prdata),
  .test_tristate (test_tristate),
  .pin_oe_n      (pin_oe_n)
);

//--- dv/gpio_tb.sv
// gpio block testbench
`timescale 1ns/1ns
`include "gpio_consts.svh"

module gpio_tb
  import gpio_pkg::*;
();

  localparam int N_RW  = 45;   // readback rounds
  localparam int N_OE  = 24;   // pad enable rounds
  localparam int N_IN  = 16;   // input value rounds
  localparam int N_IRQ = 48;   // interrupt rounds
  // 4 cycles per transfer, 5 per pin change, margin for reset and tristate steps
  localparam int N_XFER      = 5 + 2 * N_RW + 2 * N_OE + 2 * N_IN + 4 * N_IRQ;
  localparam int N_PINS      = N_IN + N_IRQ;
  localparam int CYCLE_LIMIT = 4 * N_XFER + 5 * N_PINS + 200;

  logic       pclk6;
  logic       n_reset6;
  logic       psel;
  logic       penable;
  logic       pwrite;
  gpio_addr_t paddr;
  gpio_word_t pwdata;
  gpio_word_t prdata;
  logic       pready;
  gpio_word_t pin_in;
  gpio_word_t test_tristate;
  gpio_word_t pin_out;
  gpio_word_t pin_oe_n;
  gpio_word_t interrupt;

  // reference model
  gpio_word_t dir_m;    // 1 = input
  gpio_word_t oe_m;
  gpio_word_t out_m;
  gpio_word_t int_m;    // pending rising edges
  gpio_word_t pins_m;   // settled pad level
  gpio_word_t tt_m;     // dft force

  logic [31:0] lfsr;
  int          cycles = 0;
  logic        fail_shown = 1'b0;
  logic        run_done = 1'b0;

  gpio_top i_dut (
    .pclk6         (pclk6),
    .n_reset6      (n_reset6),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pin_in        (pin_in),
    .test_tristate (test_tristate),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n),
    .interrupt     (interrupt)
  );

  //------------------------------------------------------------
  // clock and run limit
  //------------------------------------------------------------
  initial
  begin
    pclk6 = 1'b0;
    forever
    begin
      #10 pclk6 = ~pclk6;   // 20 ns period
    end
  end

  always @(posedge pclk6)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      show_fail();
      $fatal(1, "timeout");
    end
  end

  //------------------------------------------------------------
  // random source and model
  //------------------------------------------------------------
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
    begin
      lfsr = lfsr ^ 32'h80200003;   // galois taps 32 22 2 1
    end
    return b;
  endfunction

  function automatic gpio_word_t rand_word();
    gpio_word_t w;
    w = '0;
    for (int i = 0; i < `GPIO_WIDTH; i++)
    begin
      w[i] = next_bit();   // one step per bit
    end
    return w;
  endfunction

  // any offset that decodes to no register
  function automatic gpio_addr_t rand_unmapped();
    gpio_addr_t a;
    a = '0;
    for (int i = 0; i < `GPIO_ADDR_WIDTH; i++)
    begin
      a[i] = next_bit();
    end
    if (a == `GPR_DIRECTION_MODE || a == `GPR_OUTPUT_ENABLE || a == `GPR_OUTPUT_VALUE ||
        a == `GPR_INPUT_VALUE || a == `GPR_INT_STATUS)
    begin
      a = a ^ 6'h01;   // mapped offsets are even so odd ones are holes
    end
    return a;
  endfunction

  function automatic gpio_addr_t rw_addr(input int k);
    case (k % 3)
      0:       return `GPR_DIRECTION_MODE;
      1:       return `GPR_OUTPUT_ENABLE;
      default: return `GPR_OUTPUT_VALUE;
    endcase
  endfunction

  function automatic gpio_word_t model_read(input gpio_addr_t addr);
    case (addr)
      `GPR_DIRECTION_MODE: return dir_m;
      `GPR_OUTPUT_ENABLE:  return oe_m;
      `GPR_OUTPUT_VALUE:   return out_m;
      `GPR_INT_STATUS:     return int_m;
      default:             return pins_m;   // input value and holes
    endcase
  endfunction

  function automatic void model_write(input gpio_addr_t addr, input gpio_word_t data);
    case (addr)
      `GPR_DIRECTION_MODE: dir_m = data;
      `GPR_OUTPUT_ENABLE:  oe_m  = data;
      `GPR_OUTPUT_VALUE:   out_m = data;
      default: ;   // read only or unmapped
    endcase
  endfunction

  // a pad drives only when enabled, in output mode and not forced off
  function automatic gpio_word_t oe_n_model();
    gpio_word_t exp;
    for (int i = 0; i < `GPIO_WIDTH; i++)
    begin
      if (oe_m[i] && !dir_m[i] && !tt_m[i])
      begin
        exp[i] = 1'b0;   // pad driven
      end
      else
      begin
        exp[i] = 1'b1;   // high z
      end
    end
    return exp;
  endfunction

  //------------------------------------------------------------
  // checks
  //------------------------------------------------------------
  function automatic void show_fail();
    fail_shown = 1'b1;
    $display("TESTS FAILED");
  endfunction

  task automatic check_word(input string what, input gpio_word_t got, input gpio_word_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
      show_fail();
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
      show_fail();
      $fatal(1, "flag mismatch");
    end
  endtask

  //------------------------------------------------------------
  // apb driver
  //------------------------------------------------------------
  task automatic apb_transfer(input gpio_addr_t addr, input logic is_write,
                              input gpio_word_t wdata, output gpio_word_t rdata);
    @(posedge pclk6);   // setup cycle
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= is_write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge pclk6);   // access phase starts
    penable <= 1'b1;
    @(negedge pclk6);
    check_flag("pready in first access cycle", pready, 1'b0);
    do
    begin
      @(negedge pclk6);
    end
    while (!pready);
    rdata = prdata;     // valid while pready is high
    @(posedge pclk6);   // transfer ends at this edge
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input gpio_addr_t addr, input gpio_word_t data);
    gpio_word_t unused;
    apb_transfer(addr, 1'b1, data, unused);
    model_write(addr, data);
  endtask

  task automatic apb_read(input gpio_addr_t addr, output gpio_word_t data);
    apb_transfer(addr, 1'b0, '0, data);
  endtask

  task automatic read_check(input gpio_addr_t addr, input string what);
    gpio_word_t exp;
    gpio_word_t got;
    exp = model_read(addr);   // value before any clear
    apb_read(addr, got);
    check_word(what, got, exp);
    if (addr == `GPR_INT_STATUS)
    begin
      int_m = '0;   // whole word clears on read
    end
  endtask

  // new pad value held while it settles
  task automatic set_pins(input gpio_word_t v);
    @(posedge pclk6);
    pin_in <= v;
    int_m  = int_m | (v & ~pins_m & dir_m);   // 0 to 1 on input-mode pins
    pins_m = v;
    repeat (4) @(posedge pclk6);
  endtask

  //------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------
  initial
  begin
    gpio_addr_t addr;
    gpio_word_t v;
    lfsr          = 32'ha7520727;
    n_reset6      = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    pin_in        = '0;
    test_tristate = '0;
    dir_m  = `GPRV_DIRECTION_MODE;
    oe_m   = `GPRV_OUTPUT_ENABLE;
    out_m  = `GPRV_OUTPUT_VALUE;
    int_m  = `GPRV_INT_STATUS;
    pins_m = '0;
    tt_m   = '0;
    repeat (8) @(posedge pclk6);
    n_reset6 <= 1'b1;

    // reset values
    @(negedge pclk6);
    check_word("pin_oe_n after reset", pin_oe_n, '1);
    check_word("interrupt after reset", interrupt, '0);
    check_word("pin_out after reset", pin_out, '0);
    check_flag("pready after reset", pready, 1'b0);
    read_check(`GPR_DIRECTION_MODE, "direction mode after reset");
    read_check(`GPR_OUTPUT_ENABLE, "output enable after reset");
    read_check(`GPR_OUTPUT_VALUE, "output value after reset");
    read_check(`GPR_INPUT_VALUE, "input value after reset");
    read_check(`GPR_INT_STATUS, "int status after reset");

    // rw registers with a rotating target
    for (int i = 0; i < N_RW; i++)
    begin
      addr = rw_addr(i);
      v = rand_word();
      apb_write(addr, v);
      read_check(addr, "register readback");
      @(negedge pclk6);
      check_word("pin_out", pin_out, out_m);
    end

    // pad enables against direction, enable and dft force
    for (int i = 0; i < N_OE; i++)
    begin
      apb_write(`GPR_DIRECTION_MODE, rand_word());
      apb_write(`GPR_OUTPUT_ENABLE, rand_word());
      v = rand_word();
      @(posedge pclk6);
      test_tristate <= v;
      tt_m = v;
      @(negedge pclk6);
      check_word("pin_oe_n", pin_oe_n, oe_n_model());
    end
    @(posedge pclk6);
    test_tristate <= '0;
    tt_m = '0;

    // input value at mapped and unmapped offsets
    for (int i = 0; i < N_IN; i++)
    begin
      set_pins(rand_word());
      read_check(`GPR_INPUT_VALUE, "input value");
      read_check(rand_unmapped(), "unmapped read");
    end
    read_check(`GPR_INT_STATUS, "int status after input test");   // start from a clean status

    // interrupts
    apb_write(`GPR_DIRECTION_MODE, rand_word());
    for (int i = 0; i < N_IRQ; i++)
    begin
      if (next_bit())
      begin
        apb_write(`GPR_DIRECTION_MODE, rand_word());   // pins held so no edge
      end
      set_pins(rand_word());
      @(negedge pclk6);
      check_word("interrupt", interrupt, int_m);
      if (next_bit())
      begin
        read_check(`GPR_INT_STATUS, "int status");
        @(negedge pclk6);
        check_word("interrupt after status read", interrupt, int_m);
        read_check(`GPR_INT_STATUS, "int status after clear");
      end
    end

    run_done = 1'b1;
    $display("TESTS PASSED");
    $finish;
  end

  // run stopped early by a failed assertion
  final
  begin
    if (!run_done && !fail_shown)
    begin
      show_fail();
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the gpio testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module gpio_tb -o gpio_sim

# a failing run still prints its output, the verdict comes from the search
sim_out=$(./obj_dir/gpio_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- source/gpio_apb_slave.sv
// apb slave front end
`timescale 1ns/1ns
`include "gpio_consts.svh"

module gpio_apb_slave
  import gpio_pkg::*;
(
  input  logic       pclk6,
  input  logic       n_reset6,   // async, active low
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  gpio_addr_t paddr,
  input  gpio_word_t pwdata,
  output logic       pready,
  output reg_req_t   req
);

  apb_phase_e state;      // registered phase
  apb_phase_e phase;      // phase of the current cycle
  apb_phase_e state_nxt;
  reg_sel_e   sel_q;      // decoded at setup, held to the end
  logic       write_q;    // direction latched with the decode

  // address decode, unmapped falls onto input value
  function automatic reg_sel_e decode(input gpio_addr_t addr);
    reg_sel_e sel;
    case (addr)
      `GPR_DIRECTION_MODE: sel = sel_dir;
      `GPR_OUTPUT_ENABLE:  sel = sel_oe;
      `GPR_OUTPUT_VALUE:   sel = sel_out;
      `GPR_INT_STATUS:     sel = sel_int_status;
      default:             sel = sel_in;   // input value + holes
    endcase
    return sel;
  endfunction

  //------------------------------------------------------------
  // phase tracking
  //------------------------------------------------------------
  // setup is seen straight off the bus, the state flop only
  // holds the two access cycles
  assign phase = (state == apb_idle && psel && !penable) ? apb_setup : state;

  always_comb
  begin
    case (phase)
      apb_setup:  state_nxt = apb_wait;
      apb_wait:   state_nxt = (psel && penable) ? apb_access : apb_idle; // dropped psel aborts
      default:    state_nxt = apb_idle;   // access ends the transfer
    endcase
  end

  always_ff @(posedge pclk6 or negedge n_reset6)
  begin
    if (!n_reset6)
    begin
      state   <= apb_idle;
      sel_q   <= sel_in;
      write_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (phase == apb_setup)
      begin
        sel_q   <= decode(paddr);   // decode once per transfer
        write_q <= pwrite;
      end
    end
  end

  //------------------------------------------------------------
  // outputs
  //------------------------------------------------------------
  assign pready = (state == apb_access);  // fixed single wait state

  assign req.rd    = (state == apb_wait) && !write_q;   // core registers rdata here
  assign req.wr    = (state == apb_access) && write_q;  // lands at the closing edge
  assign req.sel   = sel_q;
  assign req.wdata = pwdata;  // master holds it until pready

endmodule

//--- source/gpio_consts.svh
// gpio constants
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

//------------------------------------------------------------
// widths
//------------------------------------------------------------
`define GPIO_WIDTH       16  // pins per block
`define GPIO_ADDR_WIDTH  6   // apb byte address

//------------------------------------------------------------
// register offsets
//------------------------------------------------------------
// widen these literals if the address width grows
`define GPR_DIRECTION_MODE  6'h04  // 1 = input, 0 = output
`define GPR_OUTPUT_ENABLE   6'h08  // pad drive enable
`define GPR_OUTPUT_VALUE    6'h0C  // value driven on pads
`define GPR_INPUT_VALUE     6'h10  // synchronized pad level, ro
`define GPR_INT_STATUS      6'h20  // rising edge flags, clear on read

//------------------------------------------------------------
// reset values
//------------------------------------------------------------
`define GPRV_DIRECTION_MODE  16'h0000  // all outputs
`define GPRV_OUTPUT_ENABLE   16'h0000  // pads tristated
`define GPRV_OUTPUT_VALUE    16'h0000  // drive low once enabled
`define GPRV_INPUT_VALUE     16'h0000  // reads zero until sampled
`define GPRV_INT_STATUS      16'h0000  // nothing pending

`endif

//--- source/gpio_lite_subunit.sv
// gpio register core
`timescale 1ns/1ns
`include "gpio_consts.svh"

module gpio_lite_subunit
  import gpio_pkg::*;
(
  input  logic       pclk6,
  input  logic       n_reset6,       // async, active low
  input  reg_req_t   req,            // strobes from the apb slave
  input  pin_obs_t   obs,            // level and rise from the pin stage
  input  gpio_word_t test_tristate,  // dft, forces pads to high z
  output gpio_word_t rdata,          // registered, zero outside a read
  output gpio_word_t pin_out,
  output gpio_word_t pin_oe_n,       // active low pad enable
  output gpio_word_t interrupt       // one line per pin
);

  //------------------------------------------------------------
  // register bank
  //------------------------------------------------------------
  gpio_word_t direction_mode;  // 1 = input, 0 = output    rw
  gpio_word_t output_enable;   // pad drive enable          rw
  gpio_word_t output_value;    // value to the pads         rw
  gpio_word_t int_status;      // rising edge flags         ro, clear on read

  gpio_word_t int_set;         // edge on an input-mode pin
  logic       status_clr;      // read of the status register

  // write port
  always_ff @(posedge pclk6 or negedge n_reset6)
  begin
    if (!n_reset6)
    begin
      direction_mode <= `GPRV_DIRECTION_MODE;
      output_enable  <= `GPRV_OUTPUT_ENABLE;
      output_value   <= `GPRV_OUTPUT_VALUE;
    end
    else if (req.wr)
    begin
      case (req.sel)
        sel_dir: direction_mode <= req.wdata;
        sel_oe:  output_enable  <= req.wdata;
        sel_out: output_value   <= req.wdata;
        default: ;   // status and input value are read only
      endcase
    end
  end

  //------------------------------------------------------------
  // interrupt status
  //------------------------------------------------------------
  // output-mode pins never flag, whatever their pad does
  assign int_set    = obs.rise & direction_mode;
  assign status_clr = req.rd && (req.sel == sel_int_status);

  always_ff @(posedge pclk6 or negedge n_reset6)
  begin
    if (!n_reset6)
    begin
      int_status <= `GPRV_INT_STATUS;
    end
    else
    begin
      // clear the whole word on a read, then or in new edges
      // so an edge in the read cycle is not lost
      int_status <= (int_status & {`GPIO_WIDTH{~status_clr}}) | int_set;
    end
  end

  //------------------------------------------------------------
  // read data
  //------------------------------------------------------------
  // sampled on the rd strobe, valid in the pready cycle
  always_ff @(posedge pclk6 or negedge n_reset6)
  begin
    if (!n_reset6)
    begin
      rdata <= '0;
    end
    else if (req.rd)
    begin
      case (req.sel)
        sel_dir:        rdata <= direction_mode;
        sel_oe:         rdata <= output_enable;
        sel_out:        rdata <= output_value;
        sel_int_status: rdata <= int_status;   // pre-clear value
        default:        rdata <= obs.level;    // input value, unmapped too
      endcase
    end
    else
    begin
      rdata <= '0;   // bus sees zeros outside a read
    end
  end

  //------------------------------------------------------------
  // pad control
  //------------------------------------------------------------
  assign pin_out = output_value;

  // drive only if enabled, in output mode and not forced off
  assign pin_oe_n = ~(output_enable & ~direction_mode) | test_tristate;

  assign interrupt = int_status;   // level, held until read

endmodule

//--- source/gpio_pin_sync.sv
// pad input synchronizer
`timescale 1ns/1ns
`include "gpio_consts.svh"

module gpio_pin_sync
  import gpio_pkg::*;
(
  input  logic       pclk6,
  input  logic       n_reset6,   // async, active low
  input  gpio_word_t pin_in,     // raw pads, asynchronous
  output pin_obs_t   obs
);

  gpio_word_t sync_one;   // first flop, may go metastable
  gpio_word_t sync_two;   // second flop, settled
  gpio_word_t in_value;   // input value register

  //------------------------------------------------------------
  // metastability filter and input value register
  //------------------------------------------------------------
  always_ff @(posedge pclk6 or negedge n_reset6)
  begin
    if (!n_reset6)
    begin
      sync_one <= '0;
      sync_two <= '0;
      in_value <= `GPRV_INPUT_VALUE;
    end
    else
    begin
      sync_one <= pin_in;
      sync_two <= sync_one;
      in_value <= sync_two;   // third edge after the pad
    end
  end

  // new level is high, registered level still low
  // -> rising edge this cycle, one cycle ahead of in_value
  assign obs.rise  = sync_two & ~in_value;
  assign obs.level = in_value;

endmodule

//--- source/gpio_pkg.sv
// gpio shared types
`include "gpio_consts.svh"

package gpio_pkg;

  // one bit per pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // apb byte address
  typedef logic [`GPIO_ADDR_WIDTH-1:0] gpio_addr_t;

  // slave phase, one value per bus cycle of a transfer
  typedef enum logic [1:0] {
    apb_idle,    // no transfer
    apb_setup,   // psel up, penable low
    apb_wait,    // first access cycle, pready low
    apb_access   // second access cycle, pready high
  } apb_phase_e;

  // decoded register target
  typedef enum logic [2:0] {
    sel_dir,         // direction mode
    sel_oe,          // output enable
    sel_out,         // output value
    sel_in,          // input value, also any unmapped offset
    sel_int_status   // interrupt status
  } reg_sel_e;

  // register request, slave to core
  typedef struct packed {
    logic       rd;     // one cycle, first access cycle
    logic       wr;     // one cycle, cycle with pready high
    reg_sel_e   sel;
    gpio_word_t wdata;
  } reg_req_t;

  // pin observation, sync stage to core
  typedef struct packed {
    gpio_word_t level;  // input value register
    gpio_word_t rise;   // per pin rising edge, combinational
  } pin_obs_t;

endpackage

//--- source/gpio_top.sv
// apb gpio top level
`timescale 1ns/1ns

module gpio_top
  import gpio_pkg::*;
(
  input  logic       pclk6,
  input  logic       n_reset6,       // async, active low
  // apb
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  gpio_addr_t paddr,
  input  gpio_word_t pwdata,
  output gpio_word_t prdata,
  output logic       pready,
  // pads
  input  gpio_word_t pin_in,
  input  gpio_word_t test_tristate,  // dft high z force
  output gpio_word_t pin_out,
  output gpio_word_t pin_oe_n,
  output gpio_word_t interrupt
);

  reg_req_t req;   // slave -> core
  pin_obs_t obs;   // pin stage -> core

  gpio_apb_slave i_apb (
    .pclk6    (pclk6),
    .n_reset6 (n_reset6),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pready   (pready),
    .req      (req)
  );

  gpio_pin_sync i_sync (
    .pclk6    (pclk6),
    .n_reset6 (n_reset6),
    .pin_in   (pin_in),
    .obs      (obs)
  );

  gpio_lite_subunit i_core (
    .pclk6         (pclk6),
    .n_reset6      (n_reset6),
    .req           (req),
    .obs           (obs),
    .test_tristate (test_tristate),
    .rdata         (prdata),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n),
    .interrupt     (interrupt)
  );

endmodule
